//--- common/hk_pkg.sv
//////////////////////////////////////////////////////////////////////
// housekeeping package: bus and identity widths, register map,
// register select encoding and the design ID word
//////////////////////////////////////////////////////////////////////

package hk_pkg;

  // bus geometry
  localparam int unsigned bus_aw = 20;  // decoded address window
  localparam int unsigned bus_dw = 32;  // data width

  // device identity
  localparam int unsigned dna_w = 57;
  localparam int unsigned dna_done_count = 466;  // sequencer count where readout ends

  // design identification, reserved zeros above board type 1
  localparam logic [bus_dw-1:0] id_word = {28'h0, 4'h1};

  //////////////////////////////////////////////////////////////////////
  // register offsets (byte addresses)
  //////////////////////////////////////////////////////////////////////

  localparam logic [bus_aw-1:0] reg_id        = 20'h00000;  // ro
  localparam logic [bus_aw-1:0] reg_dna_lo    = 20'h00004;  // ro, dna[31:0]
  localparam logic [bus_aw-1:0] reg_dna_hi    = 20'h00008;  // ro, dna[56:32]
  localparam logic [bus_aw-1:0] reg_loop      = 20'h0000C;  // rw, bit 0
  localparam logic [bus_aw-1:0] reg_exp_p_dir = 20'h00010;
  localparam logic [bus_aw-1:0] reg_exp_n_dir = 20'h00014;
  localparam logic [bus_aw-1:0] reg_exp_p_dat = 20'h00018;
  localparam logic [bus_aw-1:0] reg_exp_n_dat = 20'h0001C;
  localparam logic [bus_aw-1:0] reg_exp_p_in  = 20'h00020;  // ro, pin samples
  localparam logic [bus_aw-1:0] reg_exp_n_in  = 20'h00024;  // ro
  localparam logic [bus_aw-1:0] reg_status    = 20'h00028;  // ro, bit 0 dna done
  localparam logic [bus_aw-1:0] reg_led       = 20'h00030;

  // one slot per register, sel_none for anything outside the map
  typedef enum logic [3:0] {
    sel_none,
    sel_id,
    sel_dna_lo,
    sel_dna_hi,
    sel_loop,
    sel_exp_p_dir,
    sel_exp_n_dir,
    sel_exp_p_dat,
    sel_exp_n_dat,
    sel_exp_p_in,
    sel_exp_n_in,
    sel_status,
    sel_led
  } reg_sel_t;

endpackage

//--- hk/hk_bus_decode.sv
//////////////////////////////////////////////////////////////////////
// housekeeping bus decode: address to register select, gated
// write and read enables, unmapped access flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_bus_decode (
  input  logic [32-1:0]    sys_addr_i,  // full bus address
  input  logic             sys_wen_i,   // write strobe
  input  logic             sys_ren_i,   // read strobe
  output hk_pkg::reg_sel_t sel_o,       // selected register slot
  output logic             wr_en_o,     // write to a mapped slot
  output logic             rd_en_o,     // read from a mapped slot
  output logic             unmapped_o   // strobe outside the map
);

  logic [hk_pkg::bus_aw-1:0] addr;  // window offset
  logic                      mapped;
  logic                      strobe;

  assign addr   = sys_addr_i[hk_pkg::bus_aw-1:0];  // upper bits pick the window upstream
  assign strobe = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////////////////////////
  // address match
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (addr)
      hk_pkg::reg_id:        sel_o = hk_pkg::sel_id;
      hk_pkg::reg_dna_lo:    sel_o = hk_pkg::sel_dna_lo;
      hk_pkg::reg_dna_hi:    sel_o = hk_pkg::sel_dna_hi;
      hk_pkg::reg_loop:      sel_o = hk_pkg::sel_loop;
      hk_pkg::reg_exp_p_dir: sel_o = hk_pkg::sel_exp_p_dir;
      hk_pkg::reg_exp_n_dir: sel_o = hk_pkg::sel_exp_n_dir;
      hk_pkg::reg_exp_p_dat: sel_o = hk_pkg::sel_exp_p_dat;
      hk_pkg::reg_exp_n_dat: sel_o = hk_pkg::sel_exp_n_dat;
      hk_pkg::reg_exp_p_in:  sel_o = hk_pkg::sel_exp_p_in;
      hk_pkg::reg_exp_n_in:  sel_o = hk_pkg::sel_exp_n_in;
      hk_pkg::reg_status:    sel_o = hk_pkg::sel_status;
      hk_pkg::reg_led:       sel_o = hk_pkg::sel_led;
      default:               sel_o = hk_pkg::sel_none;  // hole in the map
    endcase
  end

  // read-only slots still count as mapped, regs just ignores them
  assign mapped = (sel_o != hk_pkg::sel_none);

  //////////////////////////////////////////////////////////////////////
  // enables
  //////////////////////////////////////////////////////////////////////

  assign wr_en_o    = sys_wen_i & mapped;
  assign rd_en_o    = sys_ren_i & mapped;
  assign unmapped_o = strobe & ~mapped;  // either direction

endmodule

//--- hk/hk_regs.sv
//////////////////////////////////////////////////////////////////////
// housekeeping configuration registers: digital loopback,
// expansion connector direction and data, LEDs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_regs #(
  parameter int unsigned DWL = 8,  // led width
  parameter int unsigned DWE = 8   // expansion width
) (
  input  logic             clk_i,
  input  logic             rstn_i,       // sync, active low
  // from decode
  input  hk_pkg::reg_sel_t sel_i,
  input  logic             wr_en_i,      // mapped write strobe
  input  logic [32-1:0]    wdata_i,      // whole word, low bits used
  // register contents
  output logic             loop_o,       // digital loopback
  output logic [DWE-1:0]   exp_p_dir_o,  // 1 = output
  output logic [DWE-1:0]   exp_n_dir_o,
  output logic [DWE-1:0]   exp_p_dat_o,
  output logic [DWE-1:0]   exp_n_dat_o,
  output logic [DWL-1:0]   led_o
);

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  // all of these drive pins, so reset brings the board to a quiet state
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      loop_o      <= 1'b0;
      exp_p_dir_o <= '0;  // all inputs
      exp_n_dir_o <= '0;
      exp_p_dat_o <= '0;
      exp_n_dat_o <= '0;
      led_o       <= '0;  // leds off
    end else if (wr_en_i) begin
      case (sel_i)
        hk_pkg::sel_loop: begin
          loop_o <= wdata_i[0];
        end
        hk_pkg::sel_exp_p_dir: begin
          exp_p_dir_o <= wdata_i[DWE-1:0];
        end
        hk_pkg::sel_exp_n_dir: begin
          exp_n_dir_o <= wdata_i[DWE-1:0];
        end
        hk_pkg::sel_exp_p_dat: begin
          exp_p_dat_o <= wdata_i[DWE-1:0];
        end
        hk_pkg::sel_exp_n_dat: begin
          exp_n_dat_o <= wdata_i[DWE-1:0];
        end
        hk_pkg::sel_led: begin
          led_o <= wdata_i[DWL-1:0];
        end
        default: ;  // id, dna, status, pin samples are read only
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // decode must only raise wr_en for an address it found in the map
  a_wr_mapped: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    wr_en_i |-> (sel_i != hk_pkg::sel_none)
  ) else $error("hk_regs: write enable with no register selected");

endmodule

//--- hk/hk_readback.sv
//////////////////////////////////////////////////////////////////////
// housekeeping readback: read data mux, registered ack and error
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_readback #(
  parameter int unsigned DWL = 8,
  parameter int unsigned DWE = 8
) (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  // from decode
  input  hk_pkg::reg_sel_t          sel_i,
  input  logic                      rd_en_i,
  input  logic                      wr_en_i,
  input  logic                      unmapped_i,
  // identity path
  input  logic [hk_pkg::dna_w-1:0]  dna_value_i,
  input  logic                      dna_done_i,
  // register and pin sources
  input  logic                      loop_i,
  input  logic [DWE-1:0]            exp_p_dir_i,
  input  logic [DWE-1:0]            exp_n_dir_i,
  input  logic [DWE-1:0]            exp_p_dat_i,
  input  logic [DWE-1:0]            exp_n_dat_i,
  input  logic [DWE-1:0]            exp_p_in_i,   // connector pin samples
  input  logic [DWE-1:0]            exp_n_in_i,
  input  logic [DWL-1:0]            led_i,
  // bus response
  output logic [hk_pkg::bus_dw-1:0] rdata_o,
  output logic                      ack_o,
  output logic                      err_o
);

  localparam int unsigned dw = hk_pkg::bus_dw;

  logic [dw-1:0] rd_mux;
  logic          strobe;  // any access this cycle

  assign strobe = rd_en_i | wr_en_i | unmapped_i;

  // zero extend the selected slot, sel_none falls to zero
  always_comb begin
    case (sel_i)
      hk_pkg::sel_id:        rd_mux = hk_pkg::id_word;
      hk_pkg::sel_dna_lo:    rd_mux = dna_value_i[dw-1:0];
      hk_pkg::sel_dna_hi:    rd_mux = {{(2*dw-hk_pkg::dna_w){1'b0}},
                                       dna_value_i[hk_pkg::dna_w-1:dw]};
      hk_pkg::sel_loop:      rd_mux = {{(dw-1){1'b0}}, loop_i};
      hk_pkg::sel_exp_p_dir: rd_mux = {{(dw-DWE){1'b0}}, exp_p_dir_i};
      hk_pkg::sel_exp_n_dir: rd_mux = {{(dw-DWE){1'b0}}, exp_n_dir_i};
      hk_pkg::sel_exp_p_dat: rd_mux = {{(dw-DWE){1'b0}}, exp_p_dat_i};
      hk_pkg::sel_exp_n_dat: rd_mux = {{(dw-DWE){1'b0}}, exp_n_dat_i};
      hk_pkg::sel_exp_p_in:  rd_mux = {{(dw-DWE){1'b0}}, exp_p_in_i};
      hk_pkg::sel_exp_n_in:  rd_mux = {{(dw-DWE){1'b0}}, exp_n_in_i};
      hk_pkg::sel_status:    rd_mux = {{(dw-1){1'b0}}, dna_done_i};
      hk_pkg::sel_led:       rd_mux = {{(dw-DWL){1'b0}}, led_i};
      default:               rd_mux = '0;  // unmapped reads as zero
    endcase
  end

  // data only moves on an access, held in between
  always_ff @(posedge clk_i) begin
    if (strobe) rdata_o <= rd_mux;
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= strobe;      // one cycle after the strobe
      err_o <= unmapped_i;  // qualifies this ack
    end
  end

  // decode flags one kind of access at a time
  a_one_access: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    $onehot0({rd_en_i, wr_en_i, unmapped_i})
  ) else $error("hk_readback: more than one access kind in a cycle");

endmodule

//--- hk/hk_dna_reader.sv
//////////////////////////////////////////////////////////////////////
// device identity reader: startup sequencer that drives the slow
// clock, load and shift of the identity register, and collects dout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_dna_reader (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  input  logic                     dna_dout_i,   // serial identity bit
  output logic                     dna_clk_o,    // slow clock, clk_i / 8
  output logic                     dna_read_o,   // load phase
  output logic                     dna_shift_o,  // shift phase
  output logic [hk_pkg::dna_w-1:0] dna_value_o,  // assembled identity
  output logic                     dna_done_o    // readout finished
);

  // done rises dna_done_count + 1 cycles after reset release,
  // the bench polls the status bit rather than counting on it
  localparam logic [9-1:0] done_cnt = 9'(hk_pkg::dna_done_count);

  logic [9-1:0] cnt;     // sequence counter, frozen once done
  logic         sample;  // one clk_i per slow period

  // low three bits zero puts the sample mid-way between shifter edges
  assign sample = (cnt[2:0] == 3'h0) && !dna_done_o;

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      cnt         <= '0;
      dna_clk_o   <= 1'b0;
      dna_read_o  <= 1'b0;
      dna_shift_o <= 1'b0;
      dna_done_o  <= 1'b0;
    end else begin
      if (!dna_done_o) cnt <= cnt + 9'd1;  // stops at done

      dna_clk_o   <= cnt[2];          // slow clock
      dna_read_o  <= (cnt < 9'd10);   // covers the first slow edge
      dna_shift_o <= (cnt > 9'd18);   // from the third edge on

      if (cnt >= done_cnt) dna_done_o <= 1'b1;  // sticky
    end
  end

  //////////////////////////////////////////////////////////////////////
  // value assembly
  //////////////////////////////////////////////////////////////////////

  // msb first, early samples before the load fall off the top
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dna_value_o <= '0;
    end else if (sample) begin
      dna_value_o <= {dna_value_o[hk_pkg::dna_w-2:0], dna_dout_i};
    end
  end

  // pre-load samples must all have left the value by the time it is done
  a_value_known: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    dna_done_o |-> !$isunknown(dna_value_o)
  ) else $error("hk_dna_reader: identity has unknown bits at done");

endmodule

//--- hk/hk_dna_shifter.sv
//////////////////////////////////////////////////////////////////////
// behavioral model of the on-chip identity register, load and
// shift on rising edges of its slow clock
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_dna_shifter #(
  parameter logic [hk_pkg::dna_w-1:0] DNA = 57'h0823456789ABCDE  // identity to serve
) (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic dna_clk_i,    // slow clock from reader
  input  logic dna_read_i,   // 1 = load identity
  input  logic dna_shift_i,  // 1 = shift towards msb
  output logic dna_dout_o    // current msb
);

  logic                     dna_clk_q;  // previous slow clock level
  logic                     dna_edge;   // slow clock rose
  logic [hk_pkg::dna_w-1:0] sreg;       // identity shift register

  assign dna_edge = dna_clk_i & ~dna_clk_q;

  // edge detect in the clk_i domain
  always_ff @(posedge clk_i) begin
    if (!rstn_i) dna_clk_q <= 1'b0;
    else         dna_clk_q <= dna_clk_i;
  end

  // load wins over shift, same as the silicon primitive
  always_ff @(posedge clk_i) begin
    if (dna_edge) begin
      if (dna_read_i) sreg <= DNA;
      else if (dna_shift_i) sreg <= {sreg[hk_pkg::dna_w-2:0], 1'b0};  // zero fill
    end
  end

  assign dna_dout_o = sreg[hk_pkg::dna_w-1];

endmodule

//--- hdl/hk_top.sv
//////////////////////////////////////////////////////////////////////
// housekeeping top: bus decode, config registers, readback and
// the device identity path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_top #(
  parameter int unsigned              DWL = 8,                     // led width
  parameter int unsigned              DWE = 8,                     // expansion width
  parameter logic [hk_pkg::dna_w-1:0] DNA = 57'h0823456789ABCDE  // identity value
) (
  input  logic           clk_i,
  input  logic           rstn_i,
  // system bus
  input  logic [32-1:0]  sys_addr_i,
  input  logic [32-1:0]  sys_wdata_i,
  input  logic           sys_wen_i,
  input  logic           sys_ren_i,
  output logic [32-1:0]  sys_rdata_o,
  output logic           sys_ack_o,
  output logic           sys_err_o,
  // board
  output logic [DWL-1:0] led_o,
  output logic           digital_loop_o,
  input  logic [DWE-1:0] exp_p_dat_i,  // connector pins in
  input  logic [DWE-1:0] exp_n_dat_i,
  output logic [DWE-1:0] exp_p_dat_o,
  output logic [DWE-1:0] exp_p_dir_o,  // 1 = drive
  output logic [DWE-1:0] exp_n_dat_o,
  output logic [DWE-1:0] exp_n_dir_o
);

  hk_pkg::reg_sel_t         sel;
  logic                     wr_en, rd_en, unmapped;
  logic                     dna_clk, dna_read, dna_shift, dna_dout;
  logic [hk_pkg::dna_w-1:0] dna_value;
  logic                     dna_done;

  hk_bus_decode u_decode (
    .sys_addr_i (sys_addr_i), .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .sel_o (sel), .wr_en_o (wr_en), .rd_en_o (rd_en), .unmapped_o (unmapped)
  );

  hk_regs #(.DWL (DWL), .DWE (DWE)) u_regs (
    .clk_i (clk_i), .rstn_i (rstn_i), .sel_i (sel), .wr_en_i (wr_en),
    .wdata_i (sys_wdata_i), .loop_o (digital_loop_o),
    .exp_p_dir_o (exp_p_dir_o), .exp_n_dir_o (exp_n_dir_o),
    .exp_p_dat_o (exp_p_dat_o), .exp_n_dat_o (exp_n_dat_o), .led_o (led_o)
  );

  // register outputs loop back into the mux for readback
  hk_readback #(.DWL (DWL), .DWE (DWE)) u_readback (
    .clk_i (clk_i), .rstn_i (rstn_i), .sel_i (sel), .rd_en_i (rd_en),
    .wr_en_i (wr_en), .unmapped_i (unmapped),
    .dna_value_i (dna_value), .dna_done_i (dna_done), .loop_i (digital_loop_o),
    .exp_p_dir_i (exp_p_dir_o), .exp_n_dir_i (exp_n_dir_o),
    .exp_p_dat_i (exp_p_dat_o), .exp_n_dat_i (exp_n_dat_o),
    .exp_p_in_i (exp_p_dat_i), .exp_n_in_i (exp_n_dat_i), .led_i (led_o),
    .rdata_o (sys_rdata_o), .ack_o (sys_ack_o), .err_o (sys_err_o)
  );

  hk_dna_reader u_dna_reader (
    .clk_i (clk_i), .rstn_i (rstn_i), .dna_dout_i (dna_dout),
    .dna_clk_o (dna_clk), .dna_read_o (dna_read), .dna_shift_o (dna_shift),
    .dna_value_o (dna_value), .dna_done_o (dna_done)
  );

  hk_dna_shifter #(.DNA (DNA)) u_dna_shifter (
    .clk_i (clk_i), .rstn_i (rstn_i), .dna_clk_i (dna_clk),
    .dna_read_i (dna_read), .dna_shift_i (dna_shift), .dna_dout_o (dna_dout)
  );

endmodule

//--- bench/hk_tb.sv
//////////////////////////////////////////////////////////////////////
// housekeeping testbench: clock, reset, watchdog, bus access task,
// stimulus table with expected values, per-test report and counts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hk_tb;

  localparam int DWL        = 8;    // DUT default led width
  localparam int DWE        = 8;    // DUT default expansion width
  localparam int n_rows     = 24;
  localparam int poll_limit = 600;  // cycles allowed for identity readout
  localparam int ack_limit  = 8;    // cycles before an access is given up
  // rows plus the poll, then headroom for reset and slow acks
  localparam int wd_cycles  = n_rows + poll_limit + 3 * n_rows + 100;

  localparam logic [56:0] dna_val = 57'h0823456789ABCDE;  // DUT default identity

  // register map
  localparam logic [31:0] a_id     = 32'h00;
  localparam logic [31:0] a_dna_lo = 32'h04;
  localparam logic [31:0] a_dna_hi = 32'h08;
  localparam logic [31:0] a_loop   = 32'h0C;
  localparam logic [31:0] a_p_dir  = 32'h10;
  localparam logic [31:0] a_n_dir  = 32'h14;
  localparam logic [31:0] a_p_dat  = 32'h18;
  localparam logic [31:0] a_n_dat  = 32'h1C;
  localparam logic [31:0] a_p_in   = 32'h20;
  localparam logic [31:0] a_n_in   = 32'h24;
  localparam logic [31:0] a_status = 32'h28;
  localparam logic [31:0] a_led    = 32'h30;

  logic           clk, rstn;
  logic [31:0]    sys_addr, sys_wdata, sys_rdata;
  logic           sys_wen, sys_ren, sys_ack, sys_err;
  logic [DWL-1:0] led;
  logic           loop;
  logic [DWE-1:0] pin_p, pin_n;  // connector inputs
  logic [DWE-1:0] p_dat, p_dir, n_dat, n_dir;

  // stimulus table, one access per row
  logic        tbl_wr    [n_rows];
  logic [31:0] tbl_addr  [n_rows];
  logic [31:0] tbl_wdata [n_rows];
  logic [31:0] tbl_exp   [n_rows];  // read data, or port value after a write
  logic        tbl_err   [n_rows];
  logic        tbl_chk   [n_rows];  // compare data or port
  string       tbl_name  [n_rows];

  integer      seed;
  int          n_err, n_pass, n_fail, n_fill, errs, lat, poll_cycles;
  logic [31:0] rd_data, tmp;
  logic        rd_err;
  logic [31:0] rnd_loop, rnd_pdir, rnd_ndir, rnd_pdat, rnd_ndat, rnd_led;

  hk_top DUT (
    .clk_i (clk), .rstn_i (rstn),
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata), .sys_wen_i (sys_wen),
    .sys_ren_i (sys_ren), .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack),
    .sys_err_o (sys_err), .led_o (led), .digital_loop_o (loop),
    .exp_p_dat_i (pin_p), .exp_n_dat_i (pin_n),
    .exp_p_dat_o (p_dat), .exp_p_dir_o (p_dir),
    .exp_n_dat_o (n_dat), .exp_n_dir_o (n_dir)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  // watchdog
  initial begin
    #(wd_cycles * 40);
    $display("run timed out after %0d cycles without finishing", wd_cycles);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      n_err++;
    end
  endtask

  // keep the low n bits
  function automatic logic [31:0] low_bits(input logic [31:0] v, input int n);
    low_bits = v & ~(32'hFFFF_FFFF << n);
  endfunction

  // output port behind a writable register, zero extended
  function automatic logic [31:0] port_value(input logic [31:0] addr);
    case (addr)
      a_loop:  port_value = {31'h0, loop};
      a_p_dir: port_value = 32'(p_dir);
      a_n_dir: port_value = 32'(n_dir);
      a_p_dat: port_value = 32'(p_dat);
      a_n_dat: port_value = 32'(n_dat);
      a_led:   port_value = 32'(led);
      // read-only slot, any bit set on a writable port shows up here
      default: port_value = 32'(led) | 32'(p_dir) | 32'(n_dir) | 32'(p_dat)
                            | 32'(n_dat) | {31'h0, loop};
    endcase
  endfunction

  // one strobe at a falling edge, returns at the falling edge with ack
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] data,
                            output logic err, output int cycles);
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(negedge clk);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    cycles  = 1;
    while (sys_ack !== 1'b1 && cycles < ack_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (sys_ack !== 1'b1) begin
      $display("no acknowledge for access to address 0x%08h", addr);
      n_err++;
    end
    data = sys_rdata;
    err  = sys_err;
    check_value("ack latency", 32'(cycles), 32'd1);  // always one cycle
  endtask

  task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [31:0] exp, input logic err, input logic chk,
                         input string name);
    tbl_wr[n_fill]    = wr;
    tbl_addr[n_fill]  = addr;
    tbl_wdata[n_fill] = wdata;
    tbl_exp[n_fill]   = exp;
    tbl_err[n_fill]   = err;
    tbl_chk[n_fill]   = chk;
    tbl_name[n_fill]  = name;
    n_fill++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (n_err == errs_before) begin
      n_pass++;
      $display("test %s: pass", name);
    end else begin
      n_fail++;
      $display("test %s: fail", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 95597;
    n_err     = 0;
    n_pass    = 0;
    n_fail    = 0;
    n_fill    = 0;
    rstn      = 1'b0;
    sys_addr  = 32'h0;
    sys_wdata = 32'h0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    pin_p     = '0;
    pin_n     = '0;

    rnd_loop = $random(seed);
    rnd_pdir = $random(seed);
    rnd_ndir = $random(seed);
    rnd_pdat = $random(seed);
    rnd_ndat = $random(seed);
    rnd_led  = $random(seed);

    // expected values from the register map rules
    add_row(1'b0, a_id,     32'h0, 32'h1, 1'b0, 1'b1, "read id");
    add_row(1'b1, a_id,     32'hFFFF_FFFF, 32'h0, 1'b0, 1'b1, "write id");
    add_row(1'b0, a_id,     32'h0, 32'h1, 1'b0, 1'b1, "id unchanged");
    add_row(1'b0, a_dna_lo, 32'h0, dna_val[31:0], 1'b0, 1'b1, "read dna low");
    add_row(1'b0, a_dna_hi, 32'h0, 32'(dna_val[56:32]), 1'b0, 1'b1, "read dna high");
    add_row(1'b0, a_status, 32'h0, 32'h1, 1'b0, 1'b1, "read status");
    add_row(1'b1, a_loop,   rnd_loop, low_bits(rnd_loop, 1),   1'b0, 1'b1, "write loop");
    add_row(1'b1, a_p_dir,  rnd_pdir, low_bits(rnd_pdir, DWE), 1'b0, 1'b1, "write p dir");
    add_row(1'b1, a_n_dir,  rnd_ndir, low_bits(rnd_ndir, DWE), 1'b0, 1'b1, "write n dir");
    add_row(1'b1, a_p_dat,  rnd_pdat, low_bits(rnd_pdat, DWE), 1'b0, 1'b1, "write p dat");
    add_row(1'b1, a_n_dat,  rnd_ndat, low_bits(rnd_ndat, DWE), 1'b0, 1'b1, "write n dat");
    add_row(1'b1, a_led,    rnd_led,  low_bits(rnd_led, DWL),  1'b0, 1'b1, "write led");
    add_row(1'b0, a_loop,   32'h0, low_bits(rnd_loop, 1),   1'b0, 1'b1, "read loop");
    add_row(1'b0, a_p_dir,  32'h0, low_bits(rnd_pdir, DWE), 1'b0, 1'b1, "read p dir");
    add_row(1'b0, a_n_dir,  32'h0, low_bits(rnd_ndir, DWE), 1'b0, 1'b1, "read n dir");
    add_row(1'b0, a_p_dat,  32'h0, low_bits(rnd_pdat, DWE), 1'b0, 1'b1, "read p dat");
    add_row(1'b0, a_n_dat,  32'h0, low_bits(rnd_ndat, DWE), 1'b0, 1'b1, "read n dat");
    add_row(1'b0, a_led,    32'h0, low_bits(rnd_led, DWL),  1'b0, 1'b1, "read led");

    // reset: 4 rising edges with rstn low
    repeat (4) @(negedge clk);
    rstn = 1'b1;

    tmp   = $random(seed);
    pin_p = tmp[DWE-1:0];
    tmp   = $random(seed);
    pin_n = tmp[DWE-1:0];
    add_row(1'b0, a_p_in, 32'h0, 32'(pin_p), 1'b0, 1'b1, "read p pins");
    add_row(1'b0, a_n_in, 32'h0, 32'(pin_n), 1'b0, 1'b1, "read n pins");
    add_row(1'b0, 32'h40, 32'h0, 32'h0, 1'b1, 1'b1, "read unmapped 0x40");
    add_row(1'b1, 32'h40, rnd_led, 32'h0, 1'b1, 1'b0, "write unmapped 0x40");
    add_row(1'b0, 32'h2C, 32'h0, 32'h0, 1'b1, 1'b1, "read hole 0x2c");
    add_row(1'b0, 32'h80, 32'h0, 32'h0, 1'b1, 1'b1, "read unmapped 0x80");

    // quiet board straight out of reset
    errs = n_err;
    check_value("led after reset", 32'(led), 32'h0);
    check_value("loop after reset", {31'h0, loop}, 32'h0);
    check_value("p dir after reset", 32'(p_dir), 32'h0);
    check_value("n dir after reset", 32'(n_dir), 32'h0);
    check_value("p dat after reset", 32'(p_dat), 32'h0);
    check_value("n dat after reset", 32'(n_dat), 32'h0);
    check_value("ack after reset", {31'h0, sys_ack}, 32'h0);
    bus_access(1'b0, a_id, 32'h0, rd_data, rd_err, lat);  // first ack latency
    report_test("reset state and first ack", errs);

    // wait for the identity readout through the status bit
    errs        = n_err;
    poll_cycles = 0;
    rd_data     = 32'h0;
    while (rd_data[0] !== 1'b1 && poll_cycles < poll_limit) begin
      bus_access(1'b0, a_status, 32'h0, rd_data, rd_err, lat);
      poll_cycles += lat;
    end
    if (rd_data[0] !== 1'b1) begin
      $display("identity readout not done within %0d cycles", poll_limit);
      n_err++;
    end
    report_test("identity done poll", errs);

    for (int i = 0; i < n_rows; i++) begin
      errs = n_err;
      bus_access(tbl_wr[i], tbl_addr[i], tbl_wdata[i], rd_data, rd_err, lat);
      check_value({tbl_name[i], " err"}, {31'h0, rd_err}, {31'h0, tbl_err[i]});
      if (tbl_chk[i]) begin
        if (tbl_wr[i]) check_value({tbl_name[i], " port"}, port_value(tbl_addr[i]), tbl_exp[i]);
        else check_value({tbl_name[i], " data"}, rd_data, tbl_exp[i]);
      end
      report_test(tbl_name[i], errs);
    end

    $display("tests passed %0d failed %0d, check errors %0d", n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
common/hk_pkg.sv
hk/hk_bus_decode.sv
hk/hk_regs.sv
hk/hk_readback.sv
hk/hk_dna_reader.sv
hk/hk_dna_shifter.sv
hdl/hk_top.sv
bench/hk_tb.sv

//--- Makefile
# Verilator build and run of the housekeeping testbench

TOP := hk_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
